/* hdl/cpu_pkg.sv */
package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [15:0] word_t;     // data and pc
  typedef logic [15:0] instr_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [15:0] imm_t;      // extended imm8 or branch offset

  // opcode field, bits 15..12 of the instruction
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_MOVI = 4'd6,
    OP_ADDI = 4'd7,
    OP_B    = 4'd8
  } opcode_e;

  // operand source in execute
  typedef enum logic {
    FWD_REG = 1'b0,  // value read in decode
    FWD_WB  = 1'b1   // value in the write-back register
  } fwd_sel_e;

  localparam word_t RESET_PC = 16'h0000;
  localparam int    NUM_REGS = 16;

endpackage

/* hdl/id_ex_if.sv */
`timescale 1ns/1ns

interface id_ex_if;
  logic               valid;
  cpu_pkg::opcode_e   op;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::reg_addr_t rn;      // first source, rd for addi
  cpu_pkg::reg_addr_t rm;
  logic               use_rn;
  logic               use_rm;
  cpu_pkg::word_t     rn_data;
  cpu_pkg::word_t     rm_data;
  cpu_pkg::imm_t      imm;
  cpu_pkg::word_t     pc;
  logic               writes_rd;
  logic               is_branch;

  modport producer (output valid, op, rd, rn, rm, use_rn, use_rm, rn_data, rm_data,
                    imm, pc, writes_rd, is_branch);
  modport consumer (input valid, op, rd, rn_data, rm_data, imm, pc, writes_rd);
  modport monitor  (input valid, rn, rm, use_rn, use_rm, is_branch);
endinterface

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
  input  logic            clk_i,
  input  logic            reset_2_r,
  input  cpu_pkg::instr_t instr_i,
  input  logic            flush_i,
  input  cpu_pkg::word_t  branch_target_i,
  output cpu_pkg::word_t  pc_o,
  output cpu_pkg::instr_t fetch_instr_o,
  output cpu_pkg::word_t  fetch_pc_o,
  output logic            fetch_valid_o
);

  cpu_pkg::word_t pc_q;

  assign pc_o = pc_q;  // instruction memory answers in the same cycle

  // program counter, redirect wins over the increment
  always_ff @(posedge clk_i or posedge reset_2_r) begin
    if (reset_2_r) begin
      pc_q          <= cpu_pkg::RESET_PC;
      fetch_valid_o <= 1'b0;
    end else if (flush_i) begin
      pc_q          <= branch_target_i;
      fetch_valid_o <= 1'b0;  // drop the word fetched under the branch
    end else begin
      pc_q          <= pc_q + 16'd1;
      fetch_valid_o <= 1'b1;
    end
  end

  // fetch register payload
  always_ff @(posedge clk_i) begin
    fetch_instr_o <= instr_i;
    fetch_pc_o    <= pc_q;
  end

endmodule

/* hdl/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
  input  logic               clk_i,
  input  logic               reset_2_r,
  input  cpu_pkg::instr_t    fetch_instr_i,
  input  cpu_pkg::word_t     fetch_pc_i,
  input  logic               fetch_valid_i,
  input  logic               flush_i,
  output cpu_pkg::reg_addr_t rd_addr_a_o,
  output cpu_pkg::reg_addr_t rd_addr_b_o,
  input  cpu_pkg::word_t     rd_data_a_i,
  input  cpu_pkg::word_t     rd_data_b_i,
  id_ex_if.producer          id_ex
);

  cpu_pkg::opcode_e   raw_op;
  cpu_pkg::opcode_e   dec_op;
  cpu_pkg::reg_addr_t f_rd;
  cpu_pkg::reg_addr_t f_rn;
  cpu_pkg::reg_addr_t f_rm;
  cpu_pkg::imm_t      dec_imm;
  logic               dec_use_rn;
  logic               dec_use_rm;
  logic               dec_writes_rd;
  logic               dec_is_branch;

  ////////////////////////////////////////////////////////////////////////////
  // field split and opcode decode
  ////////////////////////////////////////////////////////////////////////////
  assign raw_op = cpu_pkg::opcode_e'(fetch_instr_i[15:12]);
  assign f_rd   = fetch_instr_i[11:8];
  assign f_rn   = fetch_instr_i[7:4];
  assign f_rm   = fetch_instr_i[3:0];

  // addi accumulates into rd, so rd goes out on port a
  assign rd_addr_a_o = (raw_op == cpu_pkg::OP_ADDI) ? f_rd : f_rn;
  assign rd_addr_b_o = f_rm;

  always_comb begin
    dec_op        = cpu_pkg::OP_NOP;
    dec_use_rn    = 1'b0;
    dec_use_rm    = 1'b0;
    dec_writes_rd = 1'b0;
    dec_is_branch = 1'b0;
    dec_imm       = {8'h00, fetch_instr_i[7:0]};  // zero-extended imm8
    case (raw_op)
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
      cpu_pkg::OP_OR, cpu_pkg::OP_XOR: begin
        dec_op        = raw_op;
        dec_use_rn    = 1'b1;
        dec_use_rm    = 1'b1;
        dec_writes_rd = 1'b1;
      end
      cpu_pkg::OP_MOVI: begin
        dec_op        = raw_op;
        dec_writes_rd = 1'b1;
      end
      cpu_pkg::OP_ADDI: begin
        dec_op        = raw_op;
        dec_use_rn    = 1'b1;
        dec_writes_rd = 1'b1;
      end
      cpu_pkg::OP_B: begin
        dec_op        = raw_op;
        dec_is_branch = 1'b1;
        dec_imm       = {{4{fetch_instr_i[11]}}, fetch_instr_i[11:0]};
      end
      default: ;  // nop and unused opcodes
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge reset_2_r) begin
    if (reset_2_r) begin
      id_ex.valid     <= 1'b0;
      id_ex.writes_rd <= 1'b0;
      id_ex.is_branch <= 1'b0;
    end else if (flush_i) begin  // bubble behind a taken branch
      id_ex.valid     <= 1'b0;
      id_ex.writes_rd <= 1'b0;
      id_ex.is_branch <= 1'b0;
    end else begin
      id_ex.valid     <= fetch_valid_i;
      id_ex.writes_rd <= fetch_valid_i & dec_writes_rd;
      id_ex.is_branch <= fetch_valid_i & dec_is_branch;
    end
  end

  always_ff @(posedge clk_i) begin
    id_ex.op      <= dec_op;
    id_ex.rd      <= f_rd;
    id_ex.rn      <= rd_addr_a_o;
    id_ex.rm      <= rd_addr_b_o;
    id_ex.use_rn  <= dec_use_rn;
    id_ex.use_rm  <= dec_use_rm;
    id_ex.rn_data <= rd_data_a_i;
    id_ex.rm_data <= rd_data_b_i;
    id_ex.imm     <= dec_imm;
    id_ex.pc      <= fetch_pc_i;
  end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ns

module register_file #(
  parameter int NUM_REGS = cpu_pkg::NUM_REGS
) (
  input  logic               clk_i,
  input  logic               reset_2_r,
  input  cpu_pkg::reg_addr_t rd_addr_a_i,
  input  cpu_pkg::reg_addr_t rd_addr_b_i,
  input  logic               wr_en_i,
  input  cpu_pkg::reg_addr_t wr_addr_i,
  input  cpu_pkg::word_t     wr_data_i,
  output cpu_pkg::word_t     rd_data_a_o,
  output cpu_pkg::word_t     rd_data_b_o
);

  cpu_pkg::word_t regs_q [NUM_REGS];

  always_ff @(posedge clk_i or posedge reset_2_r) begin
    if (reset_2_r) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // write-through, a same-cycle write is seen by the reader
  assign rd_data_a_o = (wr_en_i && wr_addr_i == rd_addr_a_i) ? wr_data_i
                                                              : regs_q[rd_addr_a_i];
  assign rd_data_b_o = (wr_en_i && wr_addr_i == rd_addr_b_i) ? wr_data_i
                                                              : regs_q[rd_addr_b_i];

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
  input  logic               clk_i,
  input  logic               reset_2_r,
  input  cpu_pkg::fwd_sel_e  fwd_rn_sel_i,
  input  cpu_pkg::fwd_sel_e  fwd_rm_sel_i,
  id_ex_if.consumer          id_ex,
  output cpu_pkg::word_t     branch_target_o,
  output logic               wb_valid_o,
  output cpu_pkg::reg_addr_t wb_rd_o,
  output cpu_pkg::word_t     wb_data_o
);

  cpu_pkg::word_t op_a;
  cpu_pkg::word_t op_b;
  cpu_pkg::word_t alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // operand forwarding
  ////////////////////////////////////////////////////////////////////////////
  assign op_a = (fwd_rn_sel_i == cpu_pkg::FWD_WB) ? wb_data_o : id_ex.rn_data;
  assign op_b = (fwd_rm_sel_i == cpu_pkg::FWD_WB) ? wb_data_o : id_ex.rm_data;

  ////////////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (id_ex.op)
      cpu_pkg::OP_ADD:  alu_result = op_a + op_b;
      cpu_pkg::OP_SUB:  alu_result = op_a - op_b;
      cpu_pkg::OP_AND:  alu_result = op_a & op_b;
      cpu_pkg::OP_OR:   alu_result = op_a | op_b;
      cpu_pkg::OP_XOR:  alu_result = op_a ^ op_b;
      cpu_pkg::OP_MOVI: alu_result = id_ex.imm;
      cpu_pkg::OP_ADDI: alu_result = op_a + id_ex.imm;  // op_a holds rd here
      default:          alu_result = '0;
    endcase
  end

  // pc relative, imm already sign-extended in decode
  assign branch_target_o = id_ex.pc + id_ex.imm;

  // write-back register
  always_ff @(posedge clk_i or posedge reset_2_r) begin
    if (reset_2_r) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= id_ex.valid & id_ex.writes_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= id_ex.rd;
    wb_data_o <= alu_result;
  end

endmodule

/* hdl/hazard_ctrl.sv */
`timescale 1ns/1ns

module hazard_ctrl (
  id_ex_if.monitor           id_ex,
  input  logic               wb_valid_i,
  input  cpu_pkg::reg_addr_t wb_rd_i,
  output logic               flush_o,
  output cpu_pkg::fwd_sel_e  fwd_rn_sel_o,
  output cpu_pkg::fwd_sel_e  fwd_rm_sel_o
);

  logic rn_hit;
  logic rm_hit;

  // older result still in write-back, not yet visible in the operand latched
  assign rn_hit = wb_valid_i && id_ex.use_rn && (wb_rd_i == id_ex.rn);
  assign rm_hit = wb_valid_i && id_ex.use_rm && (wb_rd_i == id_ex.rm);

  assign fwd_rn_sel_o = rn_hit ? cpu_pkg::FWD_WB : cpu_pkg::FWD_REG;
  assign fwd_rm_sel_o = rm_hit ? cpu_pkg::FWD_WB : cpu_pkg::FWD_REG;

  // branch resolves in execute, kills fetch and decode
  assign flush_o = id_ex.valid & id_ex.is_branch;

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core #(
  parameter int NUM_REGS = cpu_pkg::NUM_REGS
) (
  input  logic               clk_i,
  input  logic               reset_2_r,
  input  cpu_pkg::instr_t    instr_i,
  output cpu_pkg::word_t     pc_o,
  output logic               wb_valid_o,
  output cpu_pkg::reg_addr_t wb_rd_o,
  output cpu_pkg::word_t     wb_data_o
);

  cpu_pkg::instr_t    fetch_instr;
  cpu_pkg::word_t     fetch_pc;
  logic               fetch_valid;
  logic               wb_valid;
  cpu_pkg::reg_addr_t wb_rd;
  cpu_pkg::word_t     wb_data;
  logic               flush;
  cpu_pkg::fwd_sel_e  fwd_rn_sel;
  cpu_pkg::fwd_sel_e  fwd_rm_sel;
  cpu_pkg::word_t     branch_target;
  cpu_pkg::reg_addr_t rd_addr_a;
  cpu_pkg::reg_addr_t rd_addr_b;
  cpu_pkg::word_t     rd_data_a;
  cpu_pkg::word_t     rd_data_b;

  id_ex_if id_ex ();

  fetch_unit fetch_unit_i (
    .clk_i           (clk_i),
    .reset_2_r       (reset_2_r),
    .instr_i         (instr_i),
    .flush_i         (flush),
    .branch_target_i (branch_target),
    .pc_o            (pc_o),
    .fetch_instr_o   (fetch_instr),
    .fetch_pc_o      (fetch_pc),
    .fetch_valid_o   (fetch_valid)
  );

  decode_unit decode_unit_i (
    .clk_i         (clk_i),
    .reset_2_r     (reset_2_r),
    .fetch_instr_i (fetch_instr),
    .fetch_pc_i    (fetch_pc),
    .fetch_valid_i (fetch_valid),
    .flush_i       (flush),
    .rd_addr_a_o   (rd_addr_a),
    .rd_addr_b_o   (rd_addr_b),
    .rd_data_a_i   (rd_data_a),
    .rd_data_b_i   (rd_data_b),
    .id_ex         (id_ex.producer)
  );

  register_file #(
    .NUM_REGS (NUM_REGS)
  ) register_file_i (
    .clk_i       (clk_i),
    .reset_2_r   (reset_2_r),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .wr_en_i     (wb_valid),
    .wr_addr_i   (wb_rd),
    .wr_data_i   (wb_data),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b)
  );

  execute_unit execute_unit_i (
    .clk_i           (clk_i),
    .reset_2_r       (reset_2_r),
    .fwd_rn_sel_i    (fwd_rn_sel),
    .fwd_rm_sel_i    (fwd_rm_sel),
    .id_ex           (id_ex.consumer),
    .branch_target_o (branch_target),
    .wb_valid_o      (wb_valid),
    .wb_rd_o         (wb_rd),
    .wb_data_o       (wb_data)
  );

  hazard_ctrl hazard_ctrl_i (
    .id_ex        (id_ex.monitor),
    .wb_valid_i   (wb_valid),
    .wb_rd_i      (wb_rd),
    .flush_o      (flush),
    .fwd_rn_sel_o (fwd_rn_sel),
    .fwd_rm_sel_o (fwd_rm_sel)
  );

  // retire port
  assign wb_valid_o = wb_valid;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule

/* test/cpu_core_properties.sv */
`timescale 1ns/1ns

module cpu_core_properties #(
  parameter int PROG_DEPTH = 256
) (
  input  logic               clk_i,
  input  logic               reset_2_r,
  input  cpu_pkg::instr_t    instr_i,
  input  cpu_pkg::word_t     pc_i,
  input  logic               flush_i,
  input  logic               wb_valid_i,
  input  cpu_pkg::reg_addr_t wb_rd_i,
  input  cpu_pkg::word_t     wb_data_i,
  input  cpu_pkg::instr_t    prog_i [PROG_DEPTH]
);

  int                 fail_count = 0;
  cpu_pkg::word_t     shadow_q [cpu_pkg::NUM_REGS];
  cpu_pkg::word_t     ref_pc_q;
  cpu_pkg::word_t     pc_last_q;
  cpu_pkg::word_t     [2:0] tgt_q;       // branch target, one entry per cycle of age
  cpu_pkg::word_t     br_target;
  logic               br_presented;
  logic               exp_found;
  cpu_pkg::reg_addr_t exp_rd;
  cpu_pkg::word_t     exp_data;
  cpu_pkg::word_t     exp_next_pc;
  logic               model_at_loop;

  ////////////////////////////////////////////////////////////////////////////
  // isa model, walks from the reference pc to the next register write
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    cpu_pkg::word_t  p;
    cpu_pkg::instr_t ins;
    cpu_pkg::word_t  a;
    cpu_pkg::word_t  b;
    cpu_pkg::word_t  imm;
    logic            stop;
    p             = ref_pc_q;
    stop          = 1'b0;
    model_at_loop = 1'b0;
    exp_rd        = '0;
    exp_data      = '0;
    exp_next_pc   = ref_pc_q;
    for (int k = 0; k < 8; k++) begin  // more than the longest run of non-writers
      if (!stop) begin
        ins         = prog_i[p[7:0]];
        a           = shadow_q[ins[7:4]];
        b           = shadow_q[ins[3:0]];
        imm         = {8'h00, ins[7:0]};
        stop        = 1'b1;
        exp_rd      = ins[11:8];
        exp_next_pc = p + 16'd1;
        exp_data    = '0;
        case (ins[15:12])
          cpu_pkg::OP_ADD:  exp_data = a + b;
          cpu_pkg::OP_SUB:  exp_data = a - b;
          cpu_pkg::OP_AND:  exp_data = a & b;
          cpu_pkg::OP_OR:   exp_data = a | b;
          cpu_pkg::OP_XOR:  exp_data = a ^ b;
          cpu_pkg::OP_MOVI: exp_data = imm;
          cpu_pkg::OP_ADDI: exp_data = shadow_q[ins[11:8]] + imm;
          cpu_pkg::OP_B: begin
            model_at_loop = (ins[11:0] == 12'd0);  // branch to itself ends the program
            stop          = model_at_loop;
            p             = p + {{4{ins[11]}}, ins[11:0]};
          end
          default: begin  // nop and undefined opcodes
            stop = 1'b0;
            p    = p + 16'd1;
          end
        endcase
      end
    end
    exp_found = stop & ~model_at_loop;
  end

  // retire one instruction per write-back pulse
  always_ff @(posedge clk_i or posedge reset_2_r) begin
    if (reset_2_r) begin
      ref_pc_q <= cpu_pkg::RESET_PC;
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (wb_valid_i && exp_found) begin
      shadow_q[exp_rd] <= exp_data;
      ref_pc_q         <= exp_next_pc;
    end
  end

  assign br_presented = (instr_i[15:12] == cpu_pkg::OP_B);
  assign br_target    = pc_i + {{4{instr_i[11]}}, instr_i[11:0]};

  always_ff @(posedge clk_i) begin
    pc_last_q <= pc_i;
    tgt_q     <= {tgt_q[1:0], br_target};
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  a_reset_pc: assert property (@(posedge clk_i)
    (reset_2_r || $fell(reset_2_r)) |-> pc_i == cpu_pkg::RESET_PC)
    else begin
      fail_count++;
      $error("error reset_pc: expected %h actual %h", cpu_pkg::RESET_PC, $sampled(pc_i));
    end

  a_reset_wb: assert property (@(posedge clk_i)
    (reset_2_r || $fell(reset_2_r)) |-> !wb_valid_i)
    else begin
      fail_count++;
      $error("retire strobe was high during reset or in the first cycle after it");
    end

  a_pc_step: assert property (@(posedge clk_i) disable iff (reset_2_r)
    !flush_i |=> pc_i == pc_last_q + 16'd1)
    else begin
      fail_count++;
      $error("error pc_step: expected %h actual %h",
             $sampled(pc_last_q) + 16'd1, $sampled(pc_i));
    end

  // a branch on the live path flushes two cycles later and redirects on the third
  a_branch: assert property (@(posedge clk_i) disable iff (reset_2_r)
    (br_presented && !flush_i) ##1 !flush_i |-> ##1 flush_i ##1 pc_i == tgt_q[2])
    else begin
      fail_count++;
      $error("error branch_target: expected %h actual %h",
             $sampled(tgt_q[2]), $sampled(pc_i));
    end

  a_wb_expected: assert property (@(posedge clk_i) disable iff (reset_2_r)
    wb_valid_i |-> exp_found)
    else begin
      fail_count++;
      $error("a register was written with no register-writing instruction left to retire");
    end

  a_wb_rd: assert property (@(posedge clk_i) disable iff (reset_2_r)
    (wb_valid_i && exp_found) |-> wb_rd_i == exp_rd)
    else begin
      fail_count++;
      $error("error wb_rd: expected %0d actual %0d", $sampled(exp_rd), $sampled(wb_rd_i));
    end

  a_wb_data: assert property (@(posedge clk_i) disable iff (reset_2_r)
    (wb_valid_i && exp_found) |-> wb_data_i == exp_data)
    else begin
      fail_count++;
      $error("error wb_data: expected %h actual %h", $sampled(exp_data), $sampled(wb_data_i));
    end

endmodule

/* test/cpu_core_tb.sv */
`timescale 1ns/1ns

module cpu_core_tb;

  localparam int          PROG_DEPTH     = 256;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          RAND_BASE      = 14;    // first random instruction
  localparam int          RAND_COUNT     = 48;
  localparam logic [15:0] LFSR_SEED      = 16'd30408;
  localparam logic [15:0] LFSR_TAPS      = 16'hb400;

  logic               clk_i;
  logic               reset_2_r;
  cpu_pkg::instr_t    instr_i;
  cpu_pkg::word_t     pc_o;
  logic               wb_valid_o;
  cpu_pkg::reg_addr_t wb_rd_o;
  cpu_pkg::word_t     wb_data_o;

  cpu_pkg::instr_t    prog_mem [PROG_DEPTH];
  logic [15:0]        lfsr_q;
  int                 timeouts;
  int                 cycles;

  cpu_core #(
    .NUM_REGS (cpu_pkg::NUM_REGS)
  ) cpu_core_i (
    .clk_i      (clk_i),
    .reset_2_r  (reset_2_r),
    .instr_i    (instr_i),
    .pc_o       (pc_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o)
  );

  bind cpu_core cpu_core_properties #(
    .PROG_DEPTH (256)
  ) props_i (
    .clk_i      (clk_i),
    .reset_2_r  (reset_2_r),
    .instr_i    (instr_i),
    .pc_i       (pc_o),
    .flush_i    (flush),
    .wb_valid_i (wb_valid_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o),
    .prog_i     (cpu_core_tb.prog_mem)
  );

  always #10 clk_i = ~clk_i;

  // instruction memory, answers the pc of the current cycle
  always @(negedge clk_i) begin
    instr_i = prog_mem[pc_o[7:0]];
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[14:0], lfsr_q[0]};
    end
  endtask

  function automatic cpu_pkg::instr_t encode(input logic [3:0] op, input logic [3:0] rd,
                                             input logic [7:0] low);
    return {op, rd, low};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // program: directed prologue, random alu body, final loop
  ////////////////////////////////////////////////////////////////////////////
  task automatic build_program();
    logic [15:0] op_bits;
    logic [15:0] fields;
    logic [3:0]  op;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog_mem[i] = {8'hf0, i[7:0]};  // undefined op tagged with its address
    end
    prog_mem[0]  = encode(cpu_pkg::OP_MOVI, 4'd1, 8'h05);
    prog_mem[1]  = encode(cpu_pkg::OP_MOVI, 4'd2, 8'h03);
    prog_mem[2]  = encode(cpu_pkg::OP_ADD,  4'd3, 8'h12);  // r2 back to back, r1 at two
    prog_mem[3]  = encode(cpu_pkg::OP_SUB,  4'd4, 8'h31);
    prog_mem[4]  = encode(cpu_pkg::OP_ADDI, 4'd4, 8'h10);  // rd as source, forwarded
    prog_mem[5]  = encode(cpu_pkg::OP_XOR,  4'd5, 8'h44);
    prog_mem[6]  = encode(cpu_pkg::OP_AND,  4'd6, 8'h34);
    prog_mem[7]  = encode(cpu_pkg::OP_OR,   4'd7, 8'h65);
    prog_mem[8]  = encode(cpu_pkg::OP_NOP,  4'd7, 8'h77);
    prog_mem[9]  = 16'ha123;                               // undefined opcode
    prog_mem[10] = {4'd8, 12'd3};                          // skip 11 and 12
    prog_mem[11] = encode(cpu_pkg::OP_MOVI, 4'd8, 8'hee);
    prog_mem[12] = encode(cpu_pkg::OP_MOVI, 4'd9, 8'hee);
    prog_mem[13] = encode(cpu_pkg::OP_ADD,  4'd8, 8'h73);
    for (int i = 0; i < RAND_COUNT; i++) begin
      take_bits(3, op_bits);
      take_bits(12, fields);
      op = 4'(op_bits % 7 + 1);  // add through addi
      prog_mem[RAND_BASE + i] = {op, fields[11:0]};
    end
    prog_mem[RAND_BASE + RAND_COUNT]     = {4'd8, 12'd2};
    prog_mem[RAND_BASE + RAND_COUNT + 1] = encode(cpu_pkg::OP_ADDI, 4'd1, 8'hff);
    prog_mem[RAND_BASE + RAND_COUNT + 2] = {4'd8, 12'd0};  // spin here
  endtask

  initial begin
    clk_i     = 1'b0;
    reset_2_r = 1'b0;
    instr_i   = '0;
    timeouts  = 0;
    lfsr_q    = LFSR_SEED;
    build_program();
    #1;
    reset_2_r = 1'b1;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_2_r = 1'b0;

    cycles = 0;
    while (!cpu_core_i.props_i.model_at_loop && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!cpu_core_i.props_i.model_at_loop) begin
      $display("timeout: the program never reached its final loop in %0d cycles",
               TIMEOUT_CYCLES);
      timeouts++;
    end
    repeat (8) @(posedge clk_i);  // a few turns of the final loop

    $display("assertion failures: %0d, timeouts: %0d",
             cpu_core_i.props_i.fail_count, timeouts);
    if (cpu_core_i.props_i.fail_count == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* cpu_core.f */
hdl/cpu_pkg.sv
hdl/id_ex_if.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/hazard_ctrl.sv
hdl/cpu_core.sv
test/cpu_core_properties.sv
test/cpu_core_tb.sv
